//--- list.f
hdl/dot_types_pkg.sv
hdl/buffer_ctrl_pkg.sv
hdl/operand_mult_array.sv
hdl/product_adder_tree.sv
hdl/result_buffer_ctrl.sv
hdl/result_ram.sv
hdl/mac_buff_top.sv
verif/tb_mac_buff.sv

//--- run_sim.sh
#!/bin/sh
# Build the MAC buffer testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_mac_buff -o tb_mac_buff \
    > build.log 2>&1 \
    && ./obj_dir/tb_mac_buff > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verif/tb_mac_buff.sv
// Testbench for the dot-product accelerator with result buffer
// Random fills against a dot-product model plus overrun offers and block reads

`default_nettype none

module tb_mac_buff;

    localparam int BUF_DEPTH     = 64;
    localparam int RESULT_W      = dot_types_pkg::RESULT_W;
    localparam int SEED          = 41982;
    localparam int FILL_TIMEOUT  = 1000;
    localparam int READY_TIMEOUT = 100;
    localparam int READ_TIMEOUT  = 200;

    logic                        CLK;
    logic                        RST_N;
    logic                        en_mac;
    dot_types_pkg::operand_vec_t operands;
    logic                        en_block_read;
    logic                        rdy_mac;
    logic                        rdy_block_read;
    logic                        mem_val_valid;
    logic [RESULT_W-1:0]         mem_val_data;

    // Expected sums in acceptance order
    logic [RESULT_W-1:0] model_q[$];

    int errors;
    int checks;
    int test_errors;

    mac_buff_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) DUT (
        .CLK            (CLK),
        .RST_N          (RST_N),
        .en_mac         (en_mac),
        .operands       (operands),
        .en_block_read  (en_block_read),
        .rdy_mac        (rdy_mac),
        .rdy_block_read (rdy_block_read),
        .mem_val_valid  (mem_val_valid),
        .mem_val_data   (mem_val_data)
    );

    // Free-running clock with a period of 40
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // ============================================================
    // Model and stimulus helpers
    // ============================================================

    // Plain sum of the four lane products in 64-bit arithmetic
    function automatic logic [RESULT_W-1:0] dot_sum(input dot_types_pkg::operand_vec_t ops);
        longint unsigned acc;
        acc = 0;
        for (int i = 0; i < dot_types_pkg::LANES; i++) begin
            acc += 64'(ops.vect_a[i]) * 64'(ops.vect_b[i]);
        end
        return RESULT_W'(acc);
    endfunction

    function automatic dot_types_pkg::operand_vec_t random_operands();
        dot_types_pkg::operand_vec_t ops;
        for (int i = 0; i < dot_types_pkg::LANES; i++) begin
            ops.vect_a[i] = 16'($urandom);
            ops.vect_b[i] = 16'($urandom);
        end
        return ops;
    endfunction

    // Corner vectors at fixed slots and random data elsewhere
    function automatic dot_types_pkg::operand_vec_t pick_operands(input bit corners,
                                                                  input int slot);
        dot_types_pkg::operand_vec_t ops;
        ops = random_operands();
        if (corners) begin
            case (slot)
                // All ones gives the largest possible sum
                0, BUF_DEPTH - 1: ops = '1;
                1: ops = '0;
                // Full A against zero B
                2: begin
                    ops.vect_a = '1;
                    ops.vect_b = '0;
                end
                5: ops.vect_a = '1;
                default: ;
            endcase
        end
        return ops;
    endfunction

    // ============================================================
    // Checks
    // ============================================================
    task automatic check_value(input logic [RESULT_W-1:0] got,
                               input logic [RESULT_W-1:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what, input int cycles);
        $display("Timeout at %0t: no %s after %0d cycles", $time, what, cycles);
        errors++;
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s finished with %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    // ============================================================
    // Sequences that start and end on a falling edge
    // ============================================================

    // Offer operations until BUF_DEPTH are taken with en_mac idle on about a third of cycles
    task automatic fill_buffer(input bit corners);
        int accepted;
        int cycles;
        dot_types_pkg::operand_vec_t ops;
        accepted = 0;
        cycles   = 0;
        while (accepted < BUF_DEPTH && cycles < FILL_TIMEOUT) begin
            ops      = pick_operands(corners, accepted);
            operands = ops;
            en_mac   = ($urandom_range(2) != 0);
            check_level(rdy_mac, 1'b1, "rdy_mac during fill");
            check_level(rdy_block_read, 1'b0, "rdy_block_read during fill");
            // Buffer must be ready for the whole fill so every offer counts
            if (en_mac) begin
                model_q.push_back(dot_sum(ops));
                accepted++;
            end
            @(negedge CLK);
            cycles++;
        end
        en_mac = 1'b0;
        if (accepted < BUF_DEPTH) begin
            report_timeout("full set of accepted operations", cycles);
        end
        check_level(rdy_mac, 1'b0, "rdy_mac after last accept");
    endtask

    // Extra offers while not ready that must all be ignored
    task automatic hold_overrun(input int n);
        en_mac = 1'b1;
        repeat (n) begin
            operands = random_operands();
            check_level(rdy_mac, 1'b0, "rdy_mac while buffer reserved");
            @(negedge CLK);
        end
        en_mac = 1'b0;
    endtask

    task automatic wait_block_ready();
        int cycles;
        cycles = 0;
        while (rdy_block_read !== 1'b1 && cycles < READY_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (rdy_block_read !== 1'b1) begin
            report_timeout("rdy_block_read", cycles);
        end
    endtask

    // Start a block read and compare every returned entry with the model
    task automatic read_block();
        int pulses;
        int cycles;
        logic [RESULT_W-1:0] exp;
        pulses        = 0;
        cycles        = 0;
        en_block_read = 1'b1;
        @(negedge CLK);
        en_block_read = 1'b0;
        check_level(rdy_block_read, 1'b0, "rdy_block_read once reading");
        while (pulses < BUF_DEPTH && cycles < READ_TIMEOUT) begin
            if (mem_val_valid === 1'b1) begin
                exp = (model_q.size() > 0) ? model_q.pop_front() : '0;
                check_value(mem_val_data, exp, $sformatf("entry %0d", pulses));
                pulses++;
            end
            @(negedge CLK);
            cycles++;
        end
        if (pulses < BUF_DEPTH) begin
            report_timeout("full set of mem_val_valid pulses", cycles);
        end
        // No stray pulses past the last entry
        repeat (8) begin
            check_level(mem_val_valid, 1'b0, "mem_val_valid after last entry");
            @(negedge CLK);
        end
        check_value(RESULT_W'(model_q.size()), '0, "entries left in model");
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        errors        = 0;
        checks        = 0;
        test_errors   = 0;
        RST_N         = 1'b0;
        en_mac        = 1'b0;
        en_block_read = 1'b0;
        operands      = '0;
        void'($urandom(SEED));

        repeat (5) @(negedge CLK);
        RST_N = 1'b1;
        @(negedge CLK);

        // Idle outputs after reset
        check_level(rdy_mac, 1'b1, "rdy_mac after reset");
        check_level(rdy_block_read, 1'b0, "rdy_block_read after reset");
        check_level(mem_val_valid, 1'b0, "mem_val_valid after reset");
        report_test(1, "reset state");

        fill_buffer(1'b1);
        report_test(2, "first fill");

        // Offers while the last results are still in the pipeline
        hold_overrun(40);
        wait_block_ready();
        report_test(3, "overrun offers");

        read_block();
        report_test(4, "first block read");

        check_level(rdy_mac, 1'b1, "rdy_mac after block read");
        fill_buffer(1'b0);
        hold_overrun(10);
        wait_block_ready();
        read_block();
        report_test(5, "second fill and read");

        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/mac_buff_top.sv
// Dot-product accelerator top
// Seven-cycle MAC pipeline feeding an on-chip result buffer with block readout

`default_nettype none

module mac_buff_top #(
    parameter int BUF_DEPTH = 64
) (
    input  logic                                CLK,
    input  logic                                RST_N,
    input  logic                                en_mac,
    input  dot_types_pkg::operand_vec_t         operands,
    input  logic                                en_block_read,
    output logic                                rdy_mac,
    output logic                                rdy_block_read,
    output logic                                mem_val_valid,
    output logic [dot_types_pkg::RESULT_W-1:0]  mem_val_data
);

    // ============================================================
    // Internal nets
    // ============================================================

    // Accepted operation strobe
    logic                                accept;

    // Multiplier to adder tree
    dot_types_pkg::product_vec_t         products;
    logic                                products_valid;

    // Adder tree to controller
    dot_types_pkg::result_t              result;

    // Controller to and from memory
    buffer_ctrl_pkg::mem_wr_t            wr;
    buffer_ctrl_pkg::mem_rd_t            rd;
    logic [dot_types_pkg::RESULT_W-1:0]  rd_data;

    // ============================================================
    // Datapath
    // ============================================================

    // Input register plus 2 multiply stages
    operand_mult_array u_mult (
        .CLK            (CLK),
        .RST_N          (RST_N),
        .accept         (accept),
        .operands       (operands),
        .products       (products),
        .products_valid (products_valid)
    );

    // 4 reduction stages
    product_adder_tree u_adder (
        .CLK            (CLK),
        .RST_N          (RST_N),
        .products       (products),
        .products_valid (products_valid),
        .result         (result)
    );

    // ============================================================
    // Buffer
    // ============================================================
    result_buffer_ctrl #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_ctrl (
        .CLK            (CLK),
        .RST_N          (RST_N),
        .en_mac         (en_mac),
        .en_block_read  (en_block_read),
        .result         (result),
        .rd_data        (rd_data),
        .accept         (accept),
        .rdy_mac        (rdy_mac),
        .rdy_block_read (rdy_block_read),
        .wr             (wr),
        .rd             (rd),
        .mem_val_valid  (mem_val_valid),
        .mem_val_data   (mem_val_data)
    );

    result_ram #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_ram (
        .CLK     (CLK),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- hdl/result_ram.sv
// Result buffer memory
// Simple dual port, synchronous write and registered read

`default_nettype none

module result_ram #(
    parameter int BUF_DEPTH = 64
) (
    input  logic                                CLK,
    input  buffer_ctrl_pkg::mem_wr_t            wr,
    input  buffer_ctrl_pkg::mem_rd_t            rd,
    output logic [dot_types_pkg::RESULT_W-1:0]  rd_data
);

    // ============================================================
    // Storage
    // ============================================================

    // One 34-bit dot product per entry
    logic [dot_types_pkg::RESULT_W-1:0] mem [BUF_DEPTH];

    // Write port
    always_ff @(posedge CLK) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read port
    // data holds until the next read request
    always_ff @(posedge CLK) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/result_buffer_ctrl.sv
// Result buffer controller
// Counts accepted operations, writes results in order and sweeps the buffer out

`default_nettype none

module result_buffer_ctrl #(
    parameter int BUF_DEPTH = 64
) (
    input  logic                                CLK,
    input  logic                                RST_N,
    input  logic                                en_mac,
    input  logic                                en_block_read,
    input  dot_types_pkg::result_t              result,
    input  logic [dot_types_pkg::RESULT_W-1:0]  rd_data,
    output logic                                accept,
    output logic                                rdy_mac,
    output logic                                rdy_block_read,
    output buffer_ctrl_pkg::mem_wr_t            wr,
    output buffer_ctrl_pkg::mem_rd_t            rd,
    output logic                                mem_val_valid,
    output logic [dot_types_pkg::RESULT_W-1:0]  mem_val_data
);

    localparam int AW = $clog2(BUF_DEPTH);
    // Accept counter runs 0..BUF_DEPTH, so one bit wider than an address
    localparam logic [AW:0]   FILL_MAX  = (AW + 1)'(BUF_DEPTH);
    localparam logic [AW-1:0] LAST_ADDR = AW'(BUF_DEPTH - 1);

    buffer_ctrl_pkg::buf_state_t state;
    buffer_ctrl_pkg::buf_state_t state_nxt;

    logic [AW:0]   acc_cnt;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    logic          wr_fire;
    logic          rd_fire;
    logic          rd_valid_q;

    // ============================================================
    // Handshake and port control
    // ============================================================

    // Readiness comes from accepted count, not from written count,
    // so operations still in the pipeline are already reserved
    assign rdy_mac = ((state == buffer_ctrl_pkg::IDLE) ||
                      (state == buffer_ctrl_pkg::WRITING)) && (acc_cnt < FILL_MAX);
    assign rdy_block_read = (state == buffer_ctrl_pkg::FULL);
    assign accept         = en_mac && rdy_mac;

    assign wr_fire = result.valid && (state == buffer_ctrl_pkg::WRITING);
    assign rd_fire = (state == buffer_ctrl_pkg::READING);

    assign wr = '{en: wr_fire, addr: wr_addr, data: result.sum};
    assign rd = '{en: rd_fire, addr: rd_addr};

    // ============================================================
    // FSM
    // ============================================================
    always_comb begin
        state_nxt = state;
        case (state)
            buffer_ctrl_pkg::IDLE: begin
                if (accept) begin
                    state_nxt = buffer_ctrl_pkg::WRITING;
                end
            end
            buffer_ctrl_pkg::WRITING: begin
                // Last entry lands this cycle
                if (wr_fire && (wr_addr == LAST_ADDR)) begin
                    state_nxt = buffer_ctrl_pkg::FULL;
                end
            end
            buffer_ctrl_pkg::FULL: begin
                if (en_block_read) begin
                    state_nxt = buffer_ctrl_pkg::READING;
                end
            end
            buffer_ctrl_pkg::READING: begin
                if (rd_addr == LAST_ADDR) begin
                    state_nxt = buffer_ctrl_pkg::IDLE;
                end
            end
            default: state_nxt = buffer_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state <= buffer_ctrl_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ============================================================
    // Counters
    // ============================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            acc_cnt <= '0;
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            // Fill count starts over once the buffer is being drained
            if (state == buffer_ctrl_pkg::READING) begin
                acc_cnt <= '0;
            end else if (accept) begin
                acc_cnt <= acc_cnt + 1'b1;
            end
            // Both addresses wrap to zero after the last entry
            if (wr_fire) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (rd_fire) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // ============================================================
    // Output stage
    // ============================================================

    // Read enable delayed to line up with the registered data
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            rd_valid_q    <= 1'b0;
            mem_val_valid <= 1'b0;
        end else begin
            rd_valid_q    <= rd_fire;
            mem_val_valid <= rd_valid_q;
        end
    end

    always_ff @(posedge CLK) begin
        mem_val_data <= rd_data;
    end

endmodule

`default_nettype wire

//--- hdl/product_adder_tree.sv
// Pipelined adder tree
// Reduces four 32-bit products to one 34-bit sum over four register stages

`default_nettype none

module product_adder_tree (
    input  logic                        CLK,
    input  logic                        RST_N,
    input  dot_types_pkg::product_vec_t products,
    input  logic                        products_valid,
    output dot_types_pkg::result_t      result
);

    localparam int PSUM_W   = dot_types_pkg::PSUM_W;
    localparam int RESULT_W = dot_types_pkg::RESULT_W;

    // Captured products
    dot_types_pkg::product_vec_t prod_q;
    logic                        prod_valid;

    // Pair sums, then their timing copy
    logic [PSUM_W-1:0]           psum_01;
    logic [PSUM_W-1:0]           psum_23;
    logic                        psum_valid;
    logic [PSUM_W-1:0]           psum_01_q;
    logic [PSUM_W-1:0]           psum_23_q;
    logic                        psum_q_valid;

    // Final sum
    logic [RESULT_W-1:0]         sum_q;
    logic                        sum_valid;

    // ============================================================
    // Valid pipeline, one bit per stage
    // ============================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            prod_valid   <= 1'b0;
            psum_valid   <= 1'b0;
            psum_q_valid <= 1'b0;
            sum_valid    <= 1'b0;
        end else begin
            prod_valid   <= products_valid;
            psum_valid   <= prod_valid;
            psum_q_valid <= psum_valid;
            sum_valid    <= psum_q_valid;
        end
    end

    // ============================================================
    // Data stages
    // ============================================================
    always_ff @(posedge CLK) begin
        // Stage A: capture
        if (products_valid) begin
            prod_q <= products;
        end
        // Stage B: lanes 0+1 and 2+3, carry kept
        psum_01   <= {1'b0, prod_q[0]} + {1'b0, prod_q[1]};
        psum_23   <= {1'b0, prod_q[2]} + {1'b0, prod_q[3]};
        // Stage C: plain register, breaks the path before the last adder
        psum_01_q <= psum_01;
        psum_23_q <= psum_23;
        // Stage D: full 34-bit sum
        sum_q     <= RESULT_W'(psum_01_q) + RESULT_W'(psum_23_q);
    end

    assign result = '{valid: sum_valid, sum: sum_q};

endmodule

`default_nettype wire

//--- hdl/operand_mult_array.sv
// Operand register and two-stage multiplier array
// Four unsigned 16x16 lanes, split on the low and high byte of operand B

`default_nettype none

module operand_mult_array (
    input  logic                        CLK,
    input  logic                        RST_N,
    input  logic                        accept,
    input  dot_types_pkg::operand_vec_t operands,
    output dot_types_pkg::product_vec_t products,
    output logic                        products_valid
);

    localparam int LANES  = dot_types_pkg::LANES;
    localparam int OP_W   = dot_types_pkg::OPERAND_W;
    localparam int PROD_W = dot_types_pkg::PRODUCT_W;
    // B is split in two halves, each partial product is A times one half
    localparam int HALF_W = OP_W / 2;
    localparam int PART_W = OP_W + HALF_W;

    dot_types_pkg::operand_vec_t     op_q;
    logic                            op_valid;
    logic [LANES-1:0][PART_W-1:0]    part_lo;
    logic [LANES-1:0][PART_W-1:0]    part_hi;
    logic                            part_valid;

    // ============================================================
    // Valid pipeline
    // ============================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            op_valid       <= 1'b0;
            part_valid     <= 1'b0;
            products_valid <= 1'b0;
        end else begin
            op_valid       <= accept;
            part_valid     <= op_valid;
            products_valid <= part_valid;
        end
    end

    // Input capture, only on an accepted operation
    always_ff @(posedge CLK) begin
        if (accept) begin
            op_q <= operands;
        end
    end

    // Stage 1: two narrow partial products per lane
    always_ff @(posedge CLK) begin
        for (int i = 0; i < LANES; i++) begin
            part_lo[i] <= op_q.vect_a[i] * op_q.vect_b[i][HALF_W-1:0];
            part_hi[i] <= op_q.vect_a[i] * op_q.vect_b[i][OP_W-1:HALF_W];
        end
    end

    // Stage 2: shift the high half into place and combine
    always_ff @(posedge CLK) begin
        for (int i = 0; i < LANES; i++) begin
            products[i] <= {part_hi[i], {HALF_W{1'b0}}} + PROD_W'(part_lo[i]);
        end
    end

endmodule

`default_nettype wire

//--- hdl/buffer_ctrl_pkg.sv
// Result buffer control types
// FSM state encoding and the write / read port bundles of the buffer memory

`default_nettype none

package buffer_ctrl_pkg;

    // Buffer address width, sized for the default depth of 64
    localparam int MEM_ADDR_W = 6;

    // Buffer FSM
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        WRITING = 2'b01,
        FULL    = 2'b10,
        READING = 2'b11
    } buf_state_t;

    // ============================================================
    // Memory port bundles
    // ============================================================

    // Write port, one entry per cycle
    typedef struct packed {
        logic                                en;
        logic [MEM_ADDR_W-1:0]               addr;
        logic [dot_types_pkg::RESULT_W-1:0]  data;
    } mem_wr_t;

    // Read request, data comes back one cycle later
    typedef struct packed {
        logic                  en;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_rd_t;

endpackage

`default_nettype wire

//--- hdl/dot_types_pkg.sv
// Dot-product datapath types
// Operand, product and result widths, plus the structs that carry them

`default_nettype none

package dot_types_pkg;

    // ============================================================
    // Datapath widths
    // ============================================================

    // Operand pairs per operation
    localparam int LANES     = 4;
    // Unsigned operand width
    localparam int OPERAND_W = 16;
    // One lane product, 16 x 16
    localparam int PRODUCT_W = 2 * OPERAND_W;
    // Sum of two products needs one carry bit
    localparam int PSUM_W    = PRODUCT_W + 1;
    // Sum of four products needs two carry bits
    localparam int RESULT_W  = PRODUCT_W + 2;

    // ============================================================
    // Bundles
    // ============================================================

    // Both input vectors of one operation, lane 0 in the low bits
    typedef struct packed {
        logic [LANES-1:0][OPERAND_W-1:0] vect_a;
        logic [LANES-1:0][OPERAND_W-1:0] vect_b;
    } operand_vec_t;

    // Per-lane products leaving the multiplier array
    typedef logic [LANES-1:0][PRODUCT_W-1:0] product_vec_t;

    // Finished dot product with its qualifier
    typedef struct packed {
        logic                valid;
        logic [RESULT_W-1:0] sum;
    } result_t;

endpackage

`default_nettype wire
